//--- acl_uart_pkg.sv
// Accelerometer terminal package
// Baud, reading and line constants shared by the UART terminal path,
// together with the reading, line and character types
`default_nettype none

package acl_uart_pkg;

  // --------------------------------------------------------------------------
  // UART timing at 20 MHz and 115200 baud
  // --------------------------------------------------------------------------
  localparam int clks_per_bit = 174;
  localparam int baud_count_bits = $clog2(clks_per_bit);
  localparam logic [baud_count_bits-1:0] baud_last = baud_count_bits'(clks_per_bit - 1);

  // Start bit, eight data bits and stop bit
  localparam int frame_bits = 10;
  localparam int frame_count_bits = $clog2(frame_bits);
  localparam logic [frame_count_bits-1:0] frame_last = frame_count_bits'(frame_bits - 1);

  // --------------------------------------------------------------------------
  // Readings and terminal line
  // --------------------------------------------------------------------------
  localparam int reading_bits = 16;
  localparam int reading_count = 4;
  localparam int line_bytes = 34;
  localparam int field_chars = 8;
  localparam int line_index_bits = $clog2(line_bytes);
  localparam logic [line_index_bits-1:0] line_last = line_index_bits'(line_bytes - 1);

  // Field labels in line order, X first
  localparam logic [8*reading_count-1:0] field_labels = "XYZT";

  // Fixed characters of the line
  localparam logic [7:0] ascii_colon = 8'h3A;
  localparam logic [7:0] ascii_space = 8'h20;
  localparam logic [7:0] ascii_cr = 8'h0D;
  localparam logic [7:0] ascii_lf = 8'h0A;

  typedef logic [reading_bits-1:0] reading_t;
  // X in the top bits, temperature in the lowest
  typedef logic [reading_count*reading_bits-1:0] reading_set_t;
  // First character in the top byte
  typedef logic [line_bytes*8-1:0] line_t;
  typedef logic [7:0] byte_t;

endpackage : acl_uart_pkg

`default_nettype wire

//--- acl_line_formatter.sv
// Reading hold register and terminal line formatter
// Keeps the last reading set seen while the feed is idle and turns it
// into the 34-character ASCII line, four hex fields then CR LF
`timescale 1ns/1ps
`default_nettype none

module acl_line_formatter (
  input wire logic s_clk_20mhz,
  input wire logic s_rst_20mhz,
  input acl_uart_pkg::reading_set_t i_readings,
  input wire logic i_readings_valid,
  input wire logic i_feed_idle,
  output acl_uart_pkg::line_t o_line
);

  import acl_uart_pkg::*;

  // Set shown on the terminal
  reading_set_t held_set;

  // Upper-case hex digit for one nibble
  function automatic byte_t hex_char(input logic [3:0] nib);
    if (nib < 4'd10) begin
      return 8'h30 + {4'h0, nib};
    end
    // 'A' is 0x41, so 0x37 plus ten
    return 8'h37 + {4'h0, nib};
  endfunction

  // --------------------------------------------------------------------------
  // Hold register
  // --------------------------------------------------------------------------
  // Capture only while idle so the text of a line cannot change
  // in the middle of its transmission
  always_ff @(posedge s_clk_20mhz) begin : p_hold_set
    if (s_rst_20mhz) begin
      held_set <= '0;
    end else if (i_readings_valid && i_feed_idle) begin
      held_set <= i_readings;
    end
  end : p_hold_set

  // --------------------------------------------------------------------------
  // Line assembly
  // --------------------------------------------------------------------------
  always_comb begin : p_form_line
    reading_t v_reading;
    int v_char;

    o_line = '0;
    for (int f = 0; f < reading_count; f++) begin
      // Field f takes reading f counted from the top of the set
      v_reading = held_set[(reading_count-1-f)*reading_bits +: reading_bits];
      v_char = f * field_chars;

      // Label and colon
      o_line[(line_bytes-1-v_char)*8 +: 8] = field_labels[(reading_count-1-f)*8 +: 8];
      o_line[(line_bytes-2-v_char)*8 +: 8] = ascii_colon;

      // Four digits, most significant nibble first
      for (int d = 0; d < 4; d++) begin
        o_line[(line_bytes-3-v_char-d)*8 +: 8] = hex_char(v_reading[(3-d)*4 +: 4]);
      end

      // Two spaces close the field
      o_line[(line_bytes-7-v_char)*8 +: 8] = ascii_space;
      o_line[(line_bytes-8-v_char)*8 +: 8] = ascii_space;
    end

    // Line ends in CR LF
    o_line[15:8] = ascii_cr;
    o_line[7:0] = ascii_lf;
  end : p_form_line

endmodule : acl_line_formatter

`default_nettype wire

//--- uart_line_feed.sv
// Terminal line feed
// Latches a full line on go and hands its characters to the UART
// transmitter one at a time over a valid/ready pair
`timescale 1ns/1ps
`default_nettype none

module uart_line_feed (
  input wire logic s_clk_20mhz,
  input wire logic s_rst_20mhz,
  input wire logic i_tx_go,
  input acl_uart_pkg::line_t i_line,
  input wire logic i_tx_ready,
  output logic o_feed_idle,
  output acl_uart_pkg::byte_t o_tx_data,
  output logic o_tx_valid
);

  import acl_uart_pkg::*;

  typedef enum logic {
    st_idle,
    st_send
  } feed_state_t;

  feed_state_t state;
  // Copy of the line being sent
  line_t line_reg;
  // Character currently offered to the transmitter
  logic [line_index_bits-1:0] byte_idx;
  logic byte_accepted;

  // A character moves when both sides agree
  assign byte_accepted = o_tx_valid && i_tx_ready;

  // --------------------------------------------------------------------------
  // Feed FSM
  // --------------------------------------------------------------------------
  always_ff @(posedge s_clk_20mhz) begin : p_feed_fsm
    if (s_rst_20mhz) begin
      state <= st_idle;
      byte_idx <= '0;
    end else begin
      case (state)
        st_idle: begin
          // Go pulses during a line are ignored, only idle accepts one
          if (i_tx_go) begin
            state <= st_send;
            byte_idx <= '0;
          end
        end
        st_send: begin
          if (byte_accepted) begin
            if (byte_idx == line_last) begin
              state <= st_idle;
            end else begin
              byte_idx <= byte_idx + 1'b1;
            end
          end
        end
        default: state <= st_idle;
      endcase
    end
  end : p_feed_fsm

  // Line copy taken on the accepted go
  always_ff @(posedge s_clk_20mhz) begin : p_line_copy
    if ((state == st_idle) && i_tx_go) begin
      line_reg <= i_line;
    end
  end : p_line_copy

  // Valid follows the state, so it rises the cycle after go
  assign o_tx_valid = (state == st_send);
  assign o_feed_idle = (state == st_idle);

  // Byte 0 is the top byte of the line
  assign o_tx_data = line_reg[(line_bytes-1-int'(byte_idx))*8 +: 8];

endmodule : uart_line_feed

`default_nettype wire

//--- uart_tx_serializer.sv
// UART transmitter, 8N1
// Takes one byte over valid/ready and shifts it out LSB first with
// start and stop bits, each held for one baud period
`timescale 1ns/1ps
`default_nettype none

module uart_tx_serializer (
  input wire logic s_clk_20mhz,
  input wire logic s_rst_20mhz,
  input acl_uart_pkg::byte_t i_tx_data,
  input wire logic i_tx_valid,
  output logic o_tx_ready,
  output logic o_uart_tx
);

  import acl_uart_pkg::*;

  // Cycles spent in the current bit
  logic [baud_count_bits-1:0] baud_cnt;
  // Position in the frame, 0 is the start bit
  logic [frame_count_bits-1:0] bit_cnt;
  // Remaining data bits with the stop bit behind them
  logic [8:0] shift_reg;
  logic bit_done;

  // End of the current bit period
  assign bit_done = (baud_cnt == baud_last);

  // --------------------------------------------------------------------------
  // Control and line
  // --------------------------------------------------------------------------
  always_ff @(posedge s_clk_20mhz) begin : p_tx_ctrl
    if (s_rst_20mhz) begin
      o_tx_ready <= 1'b1;
      o_uart_tx <= 1'b1;
      baud_cnt <= '0;
      bit_cnt <= '0;
    end else if (o_tx_ready) begin
      // Idle, line held high
      if (i_tx_valid) begin
        // Accept, drop ready and start bit on the next cycle
        o_tx_ready <= 1'b0;
        o_uart_tx <= 1'b0;
        baud_cnt <= '0;
        bit_cnt <= '0;
      end
    end else begin
      if (bit_done) begin
        baud_cnt <= '0;
        if (bit_cnt == frame_last) begin
          // Stop bit finished, ready again
          o_tx_ready <= 1'b1;
          o_uart_tx <= 1'b1;
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
          o_uart_tx <= shift_reg[0];
        end
      end else begin
        baud_cnt <= baud_cnt + 1'b1;
      end
    end
  end : p_tx_ctrl

  // --------------------------------------------------------------------------
  // Shift register
  // --------------------------------------------------------------------------
  // Loaded with the stop bit on top so it falls out last
  always_ff @(posedge s_clk_20mhz) begin : p_tx_shift
    if (o_tx_ready && i_tx_valid) begin
      shift_reg <= {1'b1, i_tx_data};
    end else if (!o_tx_ready && bit_done) begin
      shift_reg <= {1'b1, shift_reg[8:1]};
    end
  end : p_tx_shift

endmodule : uart_tx_serializer

`default_nettype wire

//--- acl_uart_top.sv
// Accelerometer serial terminal path
// Formats the held reading set as one ASCII line and sends it over
// the UART at 115200 baud on each go pulse
`timescale 1ns/1ps
`default_nettype none

module acl_uart_top (
  input wire logic s_clk_20mhz,
  input wire logic s_rst_20mhz,
  input acl_uart_pkg::reading_set_t i_readings,
  input wire logic i_readings_valid,
  input wire logic i_tx_go,
  output logic o_uart_tx
);

  import acl_uart_pkg::*;

  // Formatted line and feed status
  line_t s_line;
  logic s_feed_idle;

  // Character handshake between feed and transmitter
  byte_t s_tx_data;
  logic s_tx_valid;
  logic s_tx_ready;

  // Hold register and text assembly
  acl_line_formatter u_acl_line_formatter (
    .s_clk_20mhz(s_clk_20mhz),
    .s_rst_20mhz(s_rst_20mhz),
    .i_readings(i_readings),
    .i_readings_valid(i_readings_valid),
    .i_feed_idle(s_feed_idle),
    .o_line(s_line)
  );

  // Line to character stream
  uart_line_feed u_uart_line_feed (
    .s_clk_20mhz(s_clk_20mhz),
    .s_rst_20mhz(s_rst_20mhz),
    .i_tx_go(i_tx_go),
    .i_line(s_line),
    .i_tx_ready(s_tx_ready),
    .o_feed_idle(s_feed_idle),
    .o_tx_data(s_tx_data),
    .o_tx_valid(s_tx_valid)
  );

  // Serial line driver
  uart_tx_serializer u_uart_tx_serializer (
    .s_clk_20mhz(s_clk_20mhz),
    .s_rst_20mhz(s_rst_20mhz),
    .i_tx_data(s_tx_data),
    .i_tx_valid(s_tx_valid),
    .o_tx_ready(s_tx_ready),
    .o_uart_tx(o_uart_tx)
  );

endmodule : acl_uart_top

`default_nettype wire

//--- acl_uart_sva.sv
// UART transmitter handshake and line assertions
// Bound into every serializer instance
`timescale 1ns/1ps
`default_nettype none

module acl_uart_sva (
  input wire logic s_clk_20mhz,
  input wire logic s_rst_20mhz,
  input acl_uart_pkg::byte_t i_tx_data,
  input wire logic i_tx_valid,
  input wire logic o_tx_ready,
  input wire logic o_uart_tx
);

  // Valid stays up until the byte is taken
  a_valid_held : assert property (@(posedge s_clk_20mhz) disable iff (s_rst_20mhz)
    (i_tx_valid && !o_tx_ready) |=> i_tx_valid)
    else $error("valid fell before the byte was accepted");

  // Offered byte holds still while waiting
  a_data_stable : assert property (@(posedge s_clk_20mhz) disable iff (s_rst_20mhz)
    (i_tx_valid && !o_tx_ready) |=> $stable(i_tx_data))
    else $error("data changed while waiting for ready");

  // Idle transmitter keeps the line at mark
  a_idle_high : assert property (@(posedge s_clk_20mhz) disable iff (s_rst_20mhz)
    o_tx_ready |-> o_uart_tx)
    else $error("serial line low while the transmitter is ready");

endmodule : acl_uart_sva

bind uart_tx_serializer acl_uart_sva u_acl_uart_sva (.*);

`default_nettype wire

//--- tb_acl_uart_top.sv
// Testbench for the accelerometer serial terminal path
// Directed tests with a bit-level UART receiver, a line model
// built from the line rule, and a watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_acl_uart_top;

  import acl_uart_pkg::*;

  // One byte and one full line on the serial line, in ns
  localparam int byte_cycles = 10 * clks_per_bit;
  localparam int line_time_ns = line_bytes * byte_cycles * 50;
  // Longest wait for a start bit, covers the gap between bytes
  localparam int start_wait_cycles = 4 * clks_per_bit;

  logic s_clk_20mhz;
  logic s_rst_20mhz;
  reading_set_t readings;
  logic readings_valid;
  logic tx_go;
  logic uart_tx;

  int error_count;
  int check_count;

  acl_uart_top dut (
    .s_clk_20mhz(s_clk_20mhz),
    .s_rst_20mhz(s_rst_20mhz),
    .i_readings(readings),
    .i_readings_valid(readings_valid),
    .i_tx_go(tx_go),
    .o_uart_tx(uart_tx)
  );

  // 20 MHz clock
  initial begin : p_clock
    s_clk_20mhz = 1'b0;
    forever #25 s_clk_20mhz = ~s_clk_20mhz;
  end : p_clock

  // --------------------------------------------------------------------------
  // Line model and checking
  // --------------------------------------------------------------------------
  function automatic byte_t hex_digit(input logic [3:0] n);
    string digits;
    digits = "0123456789ABCDEF";
    return digits[n];
  endfunction

  // Character pos of the line for a given set, by the line rule
  function automatic byte_t expected_char(input reading_set_t set, input int pos);
    int field;
    int col;
    reading_t r;
    string labels;
    labels = "XYZT";
    if (pos == line_bytes - 2) begin
      return 8'h0D;
    end
    if (pos == line_bytes - 1) begin
      return 8'h0A;
    end
    field = pos / field_chars;
    col = pos % field_chars;
    // X sits in the top 16 bits of the set
    r = set[(reading_count-1-field)*reading_bits +: reading_bits];
    if (col == 0) begin
      return labels[field];
    end
    if (col == 1) begin
      return ":";
    end
    if (col >= 6) begin
      return " ";
    end
    // Columns 2..5 hold the digits, MS nibble first
    return hex_digit(r[(5-col)*4 +: 4]);
  endfunction

  task automatic check_value(input string test_name, input string what,
                             input logic [63:0] expected, input logic [63:0] actual);
    check_count++;
    if (expected !== actual) begin
      error_count++;
      $display("[FAIL] %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
    end
  endtask

  // --------------------------------------------------------------------------
  // Stimulus and serial receiver
  // --------------------------------------------------------------------------
  task automatic pulse_strobe(input reading_set_t set);
    @(posedge s_clk_20mhz);
    #2;
    readings = set;
    readings_valid = 1'b1;
    @(posedge s_clk_20mhz);
    #2;
    readings_valid = 1'b0;
  endtask

  task automatic pulse_go();
    @(posedge s_clk_20mhz);
    #2;
    tx_go = 1'b1;
    @(posedge s_clk_20mhz);
    #2;
    tx_go = 1'b0;
  endtask

  // Samples on falling clock edges, away from the DUT's update edge
  task automatic receive_byte(input string test_name, output byte_t data, output bit ok);
    int waited;
    data = '0;
    ok = 1'b0;
    waited = 0;
    @(negedge s_clk_20mhz);
    while (uart_tx && (waited < start_wait_cycles)) begin
      @(negedge s_clk_20mhz);
      waited++;
    end
    if (uart_tx) begin
      error_count++;
      $display("%s: the start bit never came on the serial line", test_name);
      return;
    end
    // Move to the middle of the start bit
    repeat (clks_per_bit / 2) @(negedge s_clk_20mhz);
    if (uart_tx) begin
      error_count++;
      $display("%s: the start bit ended too early", test_name);
      return;
    end
    // LSB first
    for (int b = 0; b < 8; b++) begin
      repeat (clks_per_bit) @(negedge s_clk_20mhz);
      data[b] = uart_tx;
    end
    repeat (clks_per_bit) @(negedge s_clk_20mhz);
    if (!uart_tx) begin
      error_count++;
      $display("%s: the stop bit is missing", test_name);
      return;
    end
    ok = 1'b1;
  endtask

  task automatic receive_line(input string test_name, input reading_set_t set);
    byte_t data;
    bit ok;
    for (int i = 0; i < line_bytes; i++) begin
      receive_byte(test_name, data, ok);
      if (!ok) begin
        break;
      end
      check_value(test_name, $sformatf("char %0d", i), 64'(expected_char(set, i)), 64'(data));
    end
  endtask

  // Counts low samples where the line should stay high
  task automatic watch_idle_line(input string test_name, input int cycles);
    int low_samples;
    low_samples = 0;
    repeat (cycles) begin
      @(negedge s_clk_20mhz);
      if (!uart_tx) begin
        low_samples++;
      end
    end
    check_value(test_name, "low samples on idle line", 64'(0), 64'(low_samples));
  endtask

  // --------------------------------------------------------------------------
  // Directed tests
  // --------------------------------------------------------------------------
  task automatic reset_idle_line();
    watch_idle_line("reset_idle", 2 * byte_cycles);
  endtask

  // Nothing strobed yet, so the held set is still zero
  task automatic zero_set_line();
    pulse_go();
    receive_line("zero_set", '0);
  endtask

  task automatic fixed_set_line();
    reading_set_t set;
    set = {16'h1234, 16'hABCD, 16'h00FF, 16'hF00F};
    pulse_strobe(set);
    pulse_go();
    receive_line("fixed_set", set);
    watch_idle_line("fixed_set", byte_cycles);
  endtask

  task automatic capture_while_busy();
    reading_set_t first;
    reading_set_t second;
    first = {16'h0A0B, 16'h0C0D, 16'h0E0F, 16'h1011};
    second = {16'hFEDC, 16'hBA98, 16'h7654, 16'h3210};
    pulse_strobe(first);
    pulse_go();
    fork
      receive_line("capture_busy", first);
      begin
        // Strobe lands in the third character
        repeat (3 * byte_cycles) @(posedge s_clk_20mhz);
        pulse_strobe(second);
      end
    join
    // Held set must still be the first one
    pulse_go();
    receive_line("capture_busy", first);
    pulse_strobe(second);
    pulse_go();
    receive_line("capture_busy", second);
  endtask

  task automatic go_while_busy();
    reading_set_t set;
    set = {16'h5A5A, 16'h0001, 16'h8000, 16'h7FFF};
    pulse_strobe(set);
    pulse_go();
    fork
      receive_line("go_busy", set);
      begin
        repeat (5 * byte_cycles) @(posedge s_clk_20mhz);
        pulse_go();
      end
    join
    watch_idle_line("go_busy", byte_cycles);
  endtask

  task automatic random_set_lines();
    reading_set_t set;
    for (int n = 0; n < 5; n++) begin
      set = {$urandom(), $urandom()};
      pulse_strobe(set);
      pulse_go();
      receive_line($sformatf("random_set_%0d", n), set);
    end
  endtask

  // --------------------------------------------------------------------------
  // Run control
  // --------------------------------------------------------------------------
  initial begin : p_main
    s_rst_20mhz = 1'b1;
    readings = '0;
    readings_valid = 1'b0;
    tx_go = 1'b0;
    error_count = 0;
    check_count = 0;
    void'($urandom(32'hd15c));
    repeat (5) @(posedge s_clk_20mhz);
    #2;
    s_rst_20mhz = 1'b0;

    reset_idle_line();
    zero_set_line();
    fixed_set_line();
    capture_while_busy();
    go_while_busy();
    random_set_lines();

    $display("Checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end : p_main

  // Eleven lines are sent, twelve line times plus two more of margin
  initial begin : p_watchdog
    #(14 * line_time_ns);
    $display("Watchdog expired before the tests finished");
    $display("Simulation failed");
    $finish;
  end : p_watchdog

endmodule : tb_acl_uart_top

`default_nettype wire

//--- build.f
acl_uart_pkg.sv
acl_line_formatter.sv
uart_line_feed.sv
uart_tx_serializer.sv
acl_uart_top.sv
acl_uart_sva.sv
tb_acl_uart_top.sv

//--- Makefile
# Verilator build and run for the accelerometer UART terminal path

TOP := tb_acl_uart_top
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f build.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

lint:
	verilator --lint-only -Wall --timing -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
